// ==== src.f ====
hw/icache_pkg.sv
hw/way_if.sv
hw/sdp_ram.sv
hw/cache_way.sv
hw/lru_table.sv
hw/icache_ctrl.sv
hw/icache_top.sv
dv/clk_rst_gen.sv
dv/icache_tb.sv

// ==== dv/icache_tb.sv ====
`timescale 1ns/1ns

module icache_tb;
    import icache_pkg::*;

    localparam int MAX_CYCLES = 2000;   // six tests at worst-case memory delay with margin
    localparam logic [31:0] ADDR_A = 32'h0000_4000;
    localparam logic [31:0] LRU_A = 32'h0001_0140;    // set 5
    localparam logic [31:0] LRU_B = LRU_A + 32'h1000;
    localparam logic [31:0] LRU_C = LRU_A + 32'h2000;
    localparam logic [31:0] UNC_ADDR = 32'h0003_07a4;
    localparam logic [31:0] FL_ADDR = 32'h0004_0a88;

    logic clk, rstn;
    logic i_rvalid, i_uncache, i_flush, i_mem_rready;
    logic [31:0] i_raddr;
    line_t i_mem_rdata;
    logic o_rready, o_idle, o_mem_rvalid;
    fetch_t o_rdata;
    logic [31:0] o_pc, o_mem_raddr;
    logic [7:0] o_mem_rlen;

    int cyc = 0;
    int errors, tests, tests_failed, err_start;
    int mem_reqs, mem_wait, acc_cnt, res_cnt, acc_cyc, res_cyc;
    int m0, r0;
    logic mem_busy, flushed, acc_unc;
    logic [31:0] acc_addr, last_addr;
    logic [7:0] last_len;
    string test_name;

    clk_rst_gen u_clk (.clk(clk), .rstn(rstn));

    icache_top dut0 (
        .clk(clk), .rstn(rstn),
        .i_rvalid(i_rvalid), .i_raddr(i_raddr), .i_uncache(i_uncache), .i_flush(i_flush),
        .o_rready(o_rready), .o_rdata(o_rdata), .o_pc(o_pc), .o_idle(o_idle),
        .o_mem_rvalid(o_mem_rvalid), .i_mem_rready(i_mem_rready),
        .o_mem_raddr(o_mem_raddr), .o_mem_rlen(o_mem_rlen), .i_mem_rdata(i_mem_rdata)
    );

    // value beside its inverse
    function automatic fetch_t word_of(input logic [31:0] v);
        return {~v, v};
    endfunction

    function automatic line_t line_fill(input logic [31:0] base);
        line_t line;
        for (int k = 0; k < 8; k++) begin
            line[k*64 +: 64] = word_of(base + 32'(8 * k));
        end
        return line;
    endfunction

    // uncached result is word 7 of the beat read from the 8-byte address
    function automatic fetch_t expected_data(input logic [31:0] addr, input logic unc);
        if (unc) begin
            return word_of((addr & ~32'h7) + 32'd56);
        end
        return word_of(addr & ~32'h7);
    endfunction

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc == MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // memory model answering after 0 to 7 cycles
    always @(negedge clk) begin
        i_mem_rready = 1'b0;
        if (rstn && o_mem_rvalid) begin
            if (!mem_busy) begin
                mem_busy = 1'b1;
                mem_wait = $urandom % 8;
                mem_reqs++;
                last_addr = o_mem_raddr;
                last_len = o_mem_rlen;
            end
            if (mem_wait == 0) begin
                i_mem_rready = 1'b1;
                i_mem_rdata = line_fill(o_mem_raddr);
                mem_busy = 1'b0;
            end else begin
                mem_wait--;
            end
        end
    end

    // accepted requests and returned results as seen at the clock edge
    always @(posedge clk) begin
        if (!rstn) begin
            acc_cnt <= 0;
            res_cnt <= 0;
        end else begin
            if (i_rvalid && (o_idle || o_rready)) begin
                acc_cnt <= acc_cnt + 1;
                acc_addr <= i_raddr;
                acc_unc <= i_uncache;
                acc_cyc <= cyc;
            end
            if (o_rready) begin
                res_cnt <= res_cnt + 1;
                res_cyc <= cyc;
            end
        end
    end

    rdata_check: assert property (@(posedge clk) disable iff (!rstn)
        o_rready && !flushed |-> o_rdata == expected_data(acc_addr, acc_unc))
    else begin
        errors++;
        $display("[FAIL] %s o_rdata: expected %h, actual %h", test_name,
                 expected_data($sampled(acc_addr), $sampled(acc_unc)), $sampled(o_rdata));
    end

    pc_check: assert property (@(posedge clk) disable iff (!rstn)
        o_rready |-> o_pc == acc_addr)
    else begin
        errors++;
        $display("[FAIL] %s o_pc: expected %h, actual %h", test_name,
                 $sampled(acc_addr), $sampled(o_pc));
    end

    flush_check: assert property (@(posedge clk) disable iff (!rstn) flushed |-> !o_rready)
    else begin
        errors++;
        $display("%s: a result came back for a flushed request", test_name);
    end

    task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (exp == act) else begin
            errors++;
            $display("[FAIL] %s %s: expected %0h, actual %0h", test_name, what, exp, act);
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err_start = errors;
    endtask

    task automatic report_test();
        tests++;
        if (errors != err_start) begin
            tests_failed++;
        end
        $display("%s: %s", test_name, (errors == err_start) ? "ok" : "failed");
    endtask

    // one request from idle that returns once its result has been seen
    task automatic fetch(input logic [31:0] addr, input logic unc);
        int n;
        n = res_cnt;
        i_rvalid = 1'b1;
        i_raddr = addr;
        i_uncache = unc;
        @(negedge clk);
        i_rvalid = 1'b0;
        while (res_cnt == n) @(negedge clk);
    endtask

    // new address every cycle with each accepted beside the previous result
    task automatic stream(input logic [31:0] base, input int n);
        int a0;
        int r1;
        a0 = acc_cnt;
        r1 = res_cnt;
        i_rvalid = 1'b1;
        i_uncache = 1'b0;
        for (int k = 0; k < n; k++) begin
            i_raddr = base + 32'(8 * k);
            @(negedge clk);
        end
        i_rvalid = 1'b0;
        @(negedge clk);
        check_value("back-to-back accepts", n, acc_cnt - a0);
        check_value("back-to-back results", n, res_cnt - r1);
    endtask

    initial begin
        void'($urandom(27176));
        i_rvalid = 1'b0;
        i_raddr = '0;
        i_uncache = 1'b0;
        i_flush = 1'b0;
        i_mem_rready = 1'b0;
        i_mem_rdata = '0;
        errors = 0;
        tests = 0;
        tests_failed = 0;
        mem_reqs = 0;
        mem_wait = 0;
        mem_busy = 1'b0;
        flushed = 1'b0;
        @(posedge rstn);

        start_test("reset_state");
        repeat (3) begin
            @(negedge clk);
            check_value("o_idle", 1, o_idle);
            check_value("o_rready", 0, o_rready);
            check_value("o_mem_rvalid", 0, o_mem_rvalid);
        end
        report_test();

        start_test("cold_miss");
        m0 = mem_reqs;
        fetch(ADDR_A + 32'h18, 1'b0);
        check_value("memory requests", 1, mem_reqs - m0);
        check_value("request address", ADDR_A, last_addr);
        check_value("request length", LINE_BURST_LEN, last_len);
        report_test();

        start_test("hit");
        m0 = mem_reqs;
        fetch(ADDR_A + 32'h30, 1'b0);
        check_value("hit latency", 1, res_cyc - acc_cyc);
        stream(ADDR_A, 8);
        check_value("memory requests", 0, mem_reqs - m0);
        report_test();

        start_test("lru_replacement");
        m0 = mem_reqs;
        fetch(LRU_A, 1'b0);
        fetch(LRU_B, 1'b0);
        fetch(LRU_A + 32'h8, 1'b0);
        fetch(LRU_C, 1'b0);
        check_value("requests for A B A C", 3, mem_reqs - m0);
        m0 = mem_reqs;
        fetch(LRU_A + 32'h10, 1'b0);
        check_value("requests for A after C", 0, mem_reqs - m0);
        fetch(LRU_B + 32'h20, 1'b0);
        check_value("requests for B after C", 1, mem_reqs - m0);
        report_test();

        start_test("uncached_read");
        m0 = mem_reqs;
        fetch(UNC_ADDR, 1'b1);
        check_value("memory requests", 1, mem_reqs - m0);
        check_value("request address", UNC_ADDR & ~32'h7, last_addr);
        check_value("request length", UNCACHED_BURST_LEN, last_len);
        fetch(UNC_ADDR, 1'b0);          // nothing was allocated
        check_value("requests after cached read", 2, mem_reqs - m0);
        check_value("request length", LINE_BURST_LEN, last_len);
        report_test();

        start_test("flush_during_miss");
        m0 = mem_reqs;
        r0 = res_cnt;
        i_rvalid = 1'b1;
        i_raddr = FL_ADDR;
        i_uncache = 1'b0;
        @(negedge clk);
        i_rvalid = 1'b0;
        while (!o_mem_rvalid) @(negedge clk);
        i_flush = 1'b1;
        flushed = 1'b1;
        @(negedge clk);
        i_flush = 1'b0;
        while (!o_idle) @(negedge clk);
        @(negedge clk);
        flushed = 1'b0;
        check_value("results for flushed request", 0, res_cnt - r0);
        fetch(FL_ADDR + 32'h8, 1'b0);   // line was filled anyway
        check_value("hit latency", 1, res_cyc - acc_cyc);
        check_value("memory requests", 1, mem_reqs - m0);
        report_test();

        $display("tests %0d, failed tests %0d, failed checks %0d", tests, tests_failed, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== dv/clk_rst_gen.sv ====
`timescale 1ns/1ns

module clk_rst_gen (
    output logic clk,
    output logic rstn
);

    localparam int HALF_PERIOD = 10;    // 20 ns clock
    localparam int RESET_CYCLES = 16;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
    end

endmodule

// ==== hw/icache_top.sv ====
`timescale 1ns/1ns

module icache_top (
    input  logic               clk,
    input  logic               rstn,
    // fetch side
    input  logic               i_rvalid,
    input  logic [31:0]        i_raddr,
    input  logic               i_uncache,
    input  logic               i_flush,
    output logic               o_rready,
    output icache_pkg::fetch_t o_rdata,
    output logic [31:0]        o_pc,
    output logic               o_idle,
    // memory side
    output logic               o_mem_rvalid,
    input  logic               i_mem_rready,
    output logic [31:0]        o_mem_raddr,
    output logic [7:0]         o_mem_rlen,
    input  icache_pkg::line_t  i_mem_rdata
);
    import icache_pkg::*;

    tag_t   lookup_tag;
    index_t lru_index;
    logic   lru_use_en;
    logic   lru_use_way;
    logic   lru_victim;

    way_if w0 ();
    way_if w1 ();

    icache_ctrl u_ctrl (
        .clk           (clk),
        .rstn          (rstn),
        .i_rvalid      (i_rvalid),
        .i_raddr       (i_raddr),
        .i_uncache     (i_uncache),
        .i_flush       (i_flush),
        .o_rready      (o_rready),
        .o_rdata       (o_rdata),
        .o_pc          (o_pc),
        .o_idle        (o_idle),
        .o_mem_rvalid  (o_mem_rvalid),
        .i_mem_rready  (i_mem_rready),
        .o_mem_raddr   (o_mem_raddr),
        .o_mem_rlen    (o_mem_rlen),
        .i_mem_rdata   (i_mem_rdata),
        .way0          (w0.ctrl),
        .way1          (w1.ctrl),
        .o_lookup_tag  (lookup_tag),
        .o_lru_index   (lru_index),
        .o_lru_use_en  (lru_use_en),
        .o_lru_use_way (lru_use_way),
        .i_lru_victim  (lru_victim)
    );

    cache_way u_way0 (
        .clk          (clk),
        .rstn         (rstn),
        .i_lookup_tag (lookup_tag),
        .bus          (w0.way)
    );

    cache_way u_way1 (
        .clk          (clk),
        .rstn         (rstn),
        .i_lookup_tag (lookup_tag),
        .bus          (w1.way)
    );

    lru_table u_lru (
        .clk       (clk),
        .rstn      (rstn),
        .i_index   (lru_index),
        .i_use_en  (lru_use_en),
        .i_use_way (lru_use_way),
        .o_victim  (lru_victim)
    );

endmodule

// ==== hw/icache_ctrl.sv ====
`timescale 1ns/1ns

module icache_ctrl (
    input  logic               clk,
    input  logic               rstn,
    // fetch side
    input  logic               i_rvalid,
    input  logic [31:0]        i_raddr,
    input  logic               i_uncache,
    input  logic               i_flush,
    output logic               o_rready,
    output icache_pkg::fetch_t o_rdata,
    output logic [31:0]        o_pc,
    output logic               o_idle,
    // memory side
    output logic               o_mem_rvalid,
    input  logic               i_mem_rready,
    output logic [31:0]        o_mem_raddr,
    output logic [7:0]         o_mem_rlen,
    input  icache_pkg::line_t  i_mem_rdata,
    // ways and lru
    way_if.ctrl                way0,
    way_if.ctrl                way1,
    output icache_pkg::tag_t   o_lookup_tag,
    output icache_pkg::index_t o_lru_index,
    output logic               o_lru_use_en,
    output logic               o_lru_use_way,
    input  logic               i_lru_victim
);
    import icache_pkg::*;

    typedef enum logic [1:0] {IDLE, LOOKUP, MISS, REFILL} state_t;

    state_t      state;
    state_t      next_state;
    logic [31:0] req_addr;      // request buffer
    logic        req_uncache;
    line_t       ret_buf;       // return buffer, one memory beat
    logic        flush_pend;    // flush seen during the miss
    logic        fwd;           // lookup of the line refilled just before
    logic        fwd_way;

    logic   accept;
    logic   hit_any;
    logic   hit_way;
    logic   lookup_ok;
    logic   refill_wr;
    index_t req_index;
    index_t new_index;
    tag_t   req_tag;
    line_t  sel_line;

    assign req_index = req_addr[OFFSET_W +: INDEX_W];
    assign new_index = i_raddr[OFFSET_W +: INDEX_W];
    assign req_tag   = req_addr[31 -: TAG_W];

    assign hit_any   = way0.hit || way1.hit || fwd;
    assign hit_way   = fwd ? fwd_way : !way0.hit;  // way0 wins if both
    assign lookup_ok = (state == LOOKUP) && hit_any && !req_uncache && !i_flush;
    assign refill_wr = (state == REFILL) && !req_uncache;

    assign o_rready = lookup_ok || ((state == REFILL) && !flush_pend && !i_flush);
    assign o_idle   = (state == IDLE);
    assign accept   = i_rvalid && (o_idle || o_rready);
    assign o_pc     = req_addr;

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (accept) next_state = LOOKUP;
            end
            LOOKUP: begin
                if (i_flush) begin
                    next_state = IDLE;
                end else if (!hit_any || req_uncache) begin
                    next_state = MISS;
                end else begin
                    next_state = accept ? LOOKUP : IDLE;
                end
            end
            MISS: begin
                if (i_mem_rready) next_state = REFILL;
            end
            REFILL: next_state = accept ? LOOKUP : IDLE;
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state      <= IDLE;
            flush_pend <= 1'b0;
            fwd        <= 1'b0;
        end else begin
            state <= next_state;
            if (state == MISS) begin
                flush_pend <= flush_pend || i_flush;
            end else begin
                flush_pend <= 1'b0;
            end
            // same line as the refill, RAM read still shows the old entry
            fwd <= accept && refill_wr && !i_uncache &&
                   (i_raddr[31:OFFSET_W] == req_addr[31:OFFSET_W]);
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr    <= i_raddr;
            req_uncache <= i_uncache;
        end
        if (o_mem_rvalid && i_mem_rready) begin
            ret_buf <= i_mem_rdata;
        end
        if (state == REFILL) begin
            fwd_way <= i_lru_victim;
        end
    end

    // memory request
    assign o_mem_rvalid = (state == MISS);
    assign o_mem_raddr  = req_uncache ?
        {req_addr[31:OFFSET_W-FETCH_SEL_W], {(OFFSET_W-FETCH_SEL_W){1'b0}}} :
        {req_addr[31:OFFSET_W], {OFFSET_W{1'b0}}};
    assign o_mem_rlen = req_uncache ? 8'(UNCACHED_BURST_LEN) : 8'(LINE_BURST_LEN);

    // new index when a request can go in, else hold the buffered one
    assign way0.rd_index = (o_idle || o_rready) ? new_index : req_index;
    assign way1.rd_index = (o_idle || o_rready) ? new_index : req_index;

    assign way0.wr_index = req_index;
    assign way0.wr_tag   = req_tag;
    assign way0.wr_line  = ret_buf;
    assign way0.wr_en    = refill_wr && !i_lru_victim;
    assign way1.wr_index = req_index;
    assign way1.wr_tag   = req_tag;
    assign way1.wr_line  = ret_buf;
    assign way1.wr_en    = refill_wr && i_lru_victim;

    assign o_lookup_tag  = req_tag;
    assign o_lru_index   = req_index;
    assign o_lru_use_en  = lookup_ok || refill_wr;
    assign o_lru_use_way = refill_wr ? i_lru_victim : hit_way;

    always_comb begin
        if ((state == REFILL) || fwd) begin
            sel_line = ret_buf;
        end else if (hit_way) begin
            sel_line = way1.rd_line;
        end else begin
            sel_line = way0.rd_line;
        end
    end

    // uncached word sits in the top of the beat
    assign o_rdata = req_uncache ? ret_buf[LINE_W-1 -: FETCH_W] :
        sel_line[req_addr[OFFSET_W-1 -: FETCH_SEL_W] * FETCH_W +: FETCH_W];

endmodule

// ==== hw/lru_table.sv ====
`timescale 1ns/1ns

module lru_table (
    input  logic               clk,
    input  logic               rstn,
    input  icache_pkg::index_t i_index,
    input  logic               i_use_en,
    input  logic               i_use_way,
    output logic               o_victim
);
    import icache_pkg::*;

    // most recently used way per set
    logic [SETS-1:0] mru;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            mru <= '0;
        end else if (i_use_en) begin
            mru[i_index] <= i_use_way;
        end
    end

    assign o_victim = ~mru[i_index];   // replace the other way

endmodule

// ==== hw/cache_way.sv ====
`timescale 1ns/1ns

module cache_way (
    input  logic             clk,
    input  logic             rstn,
    input  icache_pkg::tag_t i_lookup_tag,
    way_if.way               bus
);
    import icache_pkg::*;

    logic [SETS-1:0] valid;     // one bit per set, cleared on reset
    logic            valid_q;
    tag_t            tag_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid <= '0;
        end else if (bus.wr_en) begin
            valid[bus.wr_index] <= 1'b1;
        end
    end

    // valid read lines up with the RAM read
    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid[bus.rd_index];
        end
    end

    sdp_ram #(
        .payload_t (tag_t)
    ) u_tag_ram (
        .clk     (clk),
        .i_we    (bus.wr_en),
        .i_waddr (bus.wr_index),
        .i_wdata (bus.wr_tag),
        .i_raddr (bus.rd_index),
        .o_rdata (tag_q)
    );

    sdp_ram #(
        .payload_t (line_t)
    ) u_data_ram (
        .clk     (clk),
        .i_we    (bus.wr_en),
        .i_waddr (bus.wr_index),
        .i_wdata (bus.wr_line),
        .i_raddr (bus.rd_index),
        .o_rdata (bus.rd_line)
    );

    assign bus.hit = valid_q && (tag_q == i_lookup_tag);

endmodule

// ==== hw/sdp_ram.sv ====
`timescale 1ns/1ns

module sdp_ram #(
    parameter type payload_t = logic,
    parameter int  DEPTH = icache_pkg::SETS
) (
    input  logic               clk,
    input  logic               i_we,
    input  icache_pkg::index_t i_waddr,
    input  payload_t           i_wdata,
    input  icache_pkg::index_t i_raddr,
    output payload_t           o_rdata
);

    payload_t mem [DEPTH];

    // registered read, old data on a same-address write
    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
        o_rdata <= mem[i_raddr];
    end

endmodule

// ==== hw/way_if.sv ====
`timescale 1ns/1ns

interface way_if;
    import icache_pkg::*;

    index_t rd_index;   // lookup index, result one cycle later
    index_t wr_index;
    tag_t   wr_tag;
    line_t  wr_line;
    logic   wr_en;      // refill write into this way
    logic   hit;
    line_t  rd_line;

    modport ctrl (
        output rd_index, wr_index, wr_tag, wr_line, wr_en,
        input  hit, rd_line
    );

    modport way (
        input  rd_index, wr_index, wr_tag, wr_line, wr_en,
        output hit, rd_line
    );

endinterface

// ==== hw/icache_pkg.sv ====
package icache_pkg;

    // cache geometry
    localparam int INDEX_W = 6;                        // 64 sets
    localparam int OFFSET_W = 6;                       // 64-byte lines
    localparam int TAG_W = 32 - INDEX_W - OFFSET_W;
    localparam int SETS = 1 << INDEX_W;

    // line is one full memory beat
    localparam int LINE_W = 8 << OFFSET_W;

    // dual-issue fetch width
    localparam int FETCH_W = 64;
    localparam int FETCH_SEL_W = $clog2(LINE_W / FETCH_W);   // word select in a line

    // memory request lengths, beats minus one
    localparam int LINE_BURST_LEN = 15;
    localparam int UNCACHED_BURST_LEN = 1;

    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [LINE_W-1:0]  line_t;
    typedef logic [FETCH_W-1:0] fetch_t;

endpackage
